// ==== logic/colmix_pkg.sv ====
/* colour mixer shared definitions
   layer pixel and colour channel types, rgb struct
   palette address width, pipeline depth, default raster sizes */

`default_nettype none

package colmix_pkg;

    // layer pixel and colour channel widths
    localparam int PXL_W  = 4;
    localparam int CHAN_W = 4;

    typedef logic [PXL_W-1:0]  pxl_t;  // layer pixel, 0 = transparent
    typedef logic [CHAN_W-1:0] chan_t; // one colour channel

    // 12-bit colour, red in the top nibble
    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    // palette address = {pal_sel[2:0], layer, pixel[3:0]}
    localparam int PAL_AW = 8;

    // mux reg -> prom reg -> blank reg, counted in pixel enables
    localparam int PIPE_DLY = 3;

    // default raster, in pixels and lines
    localparam int DEF_H_TOTAL  = 384;
    localparam int DEF_H_ACTIVE = 256;
    localparam int DEF_V_TOTAL  = 264;
    localparam int DEF_V_ACTIVE = 224;
    localparam int DEF_CEN_DIV  = 8;   // clk cycles per pixel

endpackage

`default_nettype wire

// ==== logic/video_if.sv ====
/* video timing bundle
   pixel enable, blanking levels and raster counts
   source side for the timing generator, sink side for the mixer */

`timescale 1ns/1ps
`default_nettype none

interface video_if;

    logic       pxl_cen;   // one clk pulse per pixel
    logic       lhbl;      // high inside the active line
    logic       lvbl;      // high inside the active frame
    logic [8:0] hcnt;      // pixel within the line
    logic [8:0] vcnt;      // line within the frame

    modport source (
        output pxl_cen,
        output lhbl,
        output lvbl,
        output hcnt,
        output vcnt
    );

    modport sink (
        input pxl_cen,
        input lhbl,
        input lvbl,
        input hcnt,
        input vcnt
    );

endinterface

`default_nettype wire

// ==== logic/video_timing.sv ====
/* video timing generator
   clk divider for the pixel enable
   horizontal and vertical raster counters, registered blanking levels */

`timescale 1ns/1ps
`default_nettype none

module video_timing
    import colmix_pkg::*;
#(
    parameter int H_TOTAL  = DEF_H_TOTAL,
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int V_TOTAL  = DEF_V_TOTAL,
    parameter int V_ACTIVE = DEF_V_ACTIVE,
    parameter int CEN_DIV  = DEF_CEN_DIV
)(
    input  logic    clk,
    input  logic    reset,
    video_if.source vid
);

    localparam int CW = $clog2(CEN_DIV + 1);

    localparam logic [CW-1:0] CEN_LAST = CW'(CEN_DIV - 1);
    localparam logic [8:0]    H_LAST   = 9'(H_TOTAL - 1);
    localparam logic [8:0]    V_LAST   = 9'(V_TOTAL - 1);
    localparam logic [8:0]    H_ACT    = 9'(H_ACTIVE);
    localparam logic [8:0]    V_ACT    = 9'(V_ACTIVE);

    logic [CW-1:0] div_cnt;
    logic [8:0]    hcnt_nxt;
    logic [8:0]    vcnt_nxt;

    // pixel enable, last count of each divider period
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt     <= '0;
            vid.pxl_cen <= 1'b0;
        end else if (div_cnt == CEN_LAST) begin
            div_cnt     <= '0;
            vid.pxl_cen <= 1'b1;
        end else begin
            div_cnt     <= div_cnt + 1'b1;
            vid.pxl_cen <= 1'b0;
        end
    end

    // next raster position, moves only on the enable
    always_comb begin
        hcnt_nxt = vid.hcnt;
        vcnt_nxt = vid.vcnt;
        if (vid.pxl_cen) begin
            if (vid.hcnt == H_LAST) begin
                hcnt_nxt = '0;
                vcnt_nxt = (vid.vcnt == V_LAST) ? 9'd0 : vid.vcnt + 9'd1; // line done
            end else begin
                hcnt_nxt = vid.hcnt + 9'd1;
            end
        end
    end

    // blanking compared on the next count so it lines up with hcnt/vcnt
    always_ff @(posedge clk) begin
        if (reset) begin
            vid.hcnt <= '0;
            vid.vcnt <= '0;
            vid.lhbl <= 1'b1;     // position 0 is inside the active area
            vid.lvbl <= 1'b1;
        end else begin
            vid.hcnt <= hcnt_nxt;
            vid.vcnt <= vcnt_nxt;
            vid.lhbl <= hcnt_nxt < H_ACT;
            vid.lvbl <= vcnt_nxt < V_ACT;
        end
    end

endmodule

`default_nettype wire

// ==== logic/pal_prom.sv ====
/* palette memory for one colour channel
   write port on we at any clk edge
   read port registered on cen, PROM style */

`timescale 1ns/1ps
`default_nettype none

module pal_prom #(
    parameter int DW = 4,
    parameter int AW = 8
)(
    input  logic          clk,
    input  logic          cen,
    input  logic          we,
    input  logic [AW-1:0] wr_addr,
    input  logic [AW-1:0] rd_addr,
    input  logic [DW-1:0] data,
    output logic [DW-1:0] q
);

    logic [DW-1:0] mem [0:2**AW-1];

    // load port, not tied to the pixel enable
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

    // read advances with the pixel pipeline only
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/blank_dly.sv ====
/* blanking delay stage
   shifts lhbl/lvbl along with the pixel pipeline
   forces the colour to black outside the active area */

`timescale 1ns/1ps
`default_nettype none

module blank_dly
    import colmix_pkg::*;
#(
    parameter int DLY = PIPE_DLY
)(
    input  logic  clk,
    input  logic  reset,
    video_if.sink vid,
    input  rgb_t  rgb_in,
    output rgb_t  rgb_out,
    output logic  lhbl_dly,
    output logic  lvbl_dly
);

    // DLY-1 stages here, the output register is the last one
    logic [DLY-2:0] hbl_sr;
    logic [DLY-2:0] vbl_sr;
    logic           active;

    assign active = hbl_sr[DLY-2] & vbl_sr[DLY-2]; // both levels in the active area

    always_ff @(posedge clk) begin
        if (reset) begin
            hbl_sr <= '0;
            vbl_sr <= '0;
        end else if (vid.pxl_cen) begin
            hbl_sr[0] <= vid.lhbl;
            vbl_sr[0] <= vid.lvbl;
            for (int i = 1; i < DLY - 1; i++) begin
                hbl_sr[i] <= hbl_sr[i-1];
                vbl_sr[i] <= vbl_sr[i-1];
            end
        end
    end

    // final stage, lines up with the prom output
    always_ff @(posedge clk) begin
        if (reset) begin
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            rgb_out  <= '0;
        end else if (vid.pxl_cen) begin
            lhbl_dly <= hbl_sr[DLY-2];
            lvbl_dly <= vbl_sr[DLY-2];
            rgb_out  <= active ? rgb_in : '0;   // black while blanking
        end
    end

endmodule

`default_nettype wire

// ==== logic/colmix.sv ====
/* colour mixer
   sprite over tile priority mux and palette address
   red/green/blue palette proms, blanking delay stage */

`timescale 1ns/1ps
`default_nettype none

module colmix
    import colmix_pkg::*;
#(
    parameter int PAL_AW = colmix_pkg::PAL_AW
)(
    input  logic              clk,
    input  logic              reset,
    video_if.sink             vid,
    input  pxl_t              obj_pxl,
    input  pxl_t              scr_pxl,
    input  logic [2:0]        pal_sel,
    input  logic [1:0]        gfx_en,      // [0] tiles, [1] sprites
    input  logic [PAL_AW-1:0] prog_addr,
    input  chan_t             prog_data,
    input  logic [2:0]        prog_en,     // one per channel, red = bit 0
    output rgb_t              rgb,
    output logic              lhbl_dly,
    output logic              lvbl_dly
);

    logic              obj_blank;
    logic [4:0]        mux;         // {layer, pixel}
    logic [2:0]        sel_q;       // palette bank, kept with its pixel
    logic [PAL_AW-1:0] pal_addr;
    rgb_t              raw;         // prom outputs before blanking

    // transparent or disabled sprite lets the tile through
    assign obj_blank = (obj_pxl == '0) || !gfx_en[1];

    always_ff @(posedge clk) begin
        if (vid.pxl_cen) begin
            sel_q    <= pal_sel;
            mux[4]   <= obj_blank;                     // layer 1 = tiles
            mux[3:0] <= obj_blank ? (gfx_en[0] ? scr_pxl : '0) : obj_pxl;
        end
    end

    assign pal_addr = {sel_q, mux};

    pal_prom #(.DW(CHAN_W), .AW(PAL_AW)) u_red (
        .clk     (clk),
        .cen     (vid.pxl_cen),
        .we      (prog_en[0]),
        .wr_addr (prog_addr),
        .rd_addr (pal_addr),
        .data    (prog_data),
        .q       (raw.red)
    );

    pal_prom #(.DW(CHAN_W), .AW(PAL_AW)) u_green (
        .clk     (clk),
        .cen     (vid.pxl_cen),
        .we      (prog_en[1]),
        .wr_addr (prog_addr),
        .rd_addr (pal_addr),
        .data    (prog_data),
        .q       (raw.green)
    );

    pal_prom #(.DW(CHAN_W), .AW(PAL_AW)) u_blue (
        .clk     (clk),
        .cen     (vid.pxl_cen),
        .we      (prog_en[2]),
        .wr_addr (prog_addr),
        .rd_addr (pal_addr),
        .data    (prog_data),
        .q       (raw.blue)
    );

    // blanking delayed over the whole pipe: mux, prom, output
    blank_dly #(.DLY(PIPE_DLY)) u_blank (
        .clk      (clk),
        .reset    (reset),
        .vid      (vid),
        .rgb_in   (raw),
        .rgb_out  (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

endmodule

`default_nettype wire

// ==== logic/colmix_top.sv ====
/* colour mixing stage, top level
   video timing generator and colour mixer
   raster counts brought out for the layer pixel source */

`timescale 1ns/1ps
`default_nettype none

module colmix_top
    import colmix_pkg::*;
#(
    parameter int H_TOTAL  = DEF_H_TOTAL,
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int V_TOTAL  = DEF_V_TOTAL,
    parameter int V_ACTIVE = DEF_V_ACTIVE,
    parameter int CEN_DIV  = DEF_CEN_DIV
)(
    input  logic              clk,
    input  logic              reset,
    input  pxl_t              obj_pxl,
    input  pxl_t              scr_pxl,
    input  logic [2:0]        pal_sel,
    input  logic [1:0]        gfx_en,
    input  logic [PAL_AW-1:0] prog_addr,
    input  chan_t             prog_data,
    input  logic [2:0]        prog_en,
    output logic              pxl_cen,
    output logic              lhbl,
    output logic              lvbl,
    output logic [8:0]        hcnt,
    output logic [8:0]        vcnt,
    output chan_t             red,
    output chan_t             green,
    output chan_t             blue,
    output logic              lhbl_dly,
    output logic              lvbl_dly
);

    video_if vid ();
    rgb_t    rgb;

    // beam position out to whoever draws the layers
    assign pxl_cen = vid.pxl_cen;
    assign lhbl    = vid.lhbl;
    assign lvbl    = vid.lvbl;
    assign hcnt    = vid.hcnt;
    assign vcnt    = vid.vcnt;

    assign red   = rgb.red;
    assign green = rgb.green;
    assign blue  = rgb.blue;

    video_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .CEN_DIV  (CEN_DIV)
    ) u_timing (
        .clk   (clk),
        .reset (reset),
        .vid   (vid.source)
    );

    colmix #(.PAL_AW(PAL_AW)) u_colmix (
        .clk       (clk),
        .reset     (reset),
        .vid       (vid.sink),
        .obj_pxl   (obj_pxl),
        .scr_pxl   (scr_pxl),
        .pal_sel   (pal_sel),
        .gfx_en    (gfx_en),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .rgb       (rgb),
        .lhbl_dly  (lhbl_dly),
        .lvbl_dly  (lvbl_dly)
    );

endmodule

`default_nettype wire

// ==== sim/colmix_tb.sv ====
/* colour mixer testbench
   reset and raster checks, palette load with a kept copy
   tile, sprite, blanking and random pixel runs against a reference queue */

`timescale 1ns/1ps
`default_nettype none

module colmix_tb
    import colmix_pkg::*;
();

    localparam int H_TOT   = 32;
    localparam int H_ACT   = 24;
    localparam int V_TOT   = 12;
    localparam int V_ACT   = 8;
    localparam int CEN_DIV = 4;
    localparam int FRAME_PIX = H_TOT * V_TOT;              // enables per frame
    localparam int LOAD_CYC  = 3 * (2 ** PAL_AW);          // one write per channel entry
    localparam int RUN_CYC   = 4 * FRAME_PIX * CEN_DIV + LOAD_CYC;
    localparam int LIMIT     = 2 * RUN_CYC;

    typedef struct packed {
        rgb_t rgb;
        logic lhbl;
        logic lvbl;
    } exp_t;

    logic              clk = 1'b0;
    logic              reset;
    pxl_t              obj_pxl, scr_pxl;
    logic [2:0]        pal_sel;
    logic [1:0]        gfx_en;
    logic [PAL_AW-1:0] prog_addr;
    chan_t             prog_data;
    logic [2:0]        prog_en;
    logic              pxl_cen, lhbl, lvbl, lhbl_dly, lvbl_dly;
    logic [8:0]        hcnt, vcnt;
    chan_t             red, green, blue;

    chan_t pal [3][2**PAL_AW];   // copy of what went into the proms
    exp_t  exp_q [$];            // one entry per pixel in flight
    rgb_t  exp_rgb;              // head of queue, compared on the next enable
    logic  exp_lhbl, exp_lvbl;
    logic  chk_en = 1'b0;
    logic  ras_on = 1'b0;
    int    ref_h, ref_v, since_cen, n_wrap, n_ras, ras_err;
    int    err_cnt, n_pix, n_blank, cyc, mark, blank_mark;

    always #20 clk = ~clk;

    colmix_top #(
        .H_TOTAL (H_TOT), .H_ACTIVE (H_ACT), .V_TOTAL (V_TOT), .V_ACTIVE (V_ACT),
        .CEN_DIV (CEN_DIV)
    ) u_colmix_top (
        .clk (clk), .reset (reset), .obj_pxl (obj_pxl), .scr_pxl (scr_pxl),
        .pal_sel (pal_sel), .gfx_en (gfx_en), .prog_addr (prog_addr),
        .prog_data (prog_data), .prog_en (prog_en), .pxl_cen (pxl_cen),
        .lhbl (lhbl), .lvbl (lvbl), .hcnt (hcnt), .vcnt (vcnt), .red (red),
        .green (green), .blue (blue), .lhbl_dly (lhbl_dly), .lvbl_dly (lvbl_dly)
    );

    // output pipeline checks, sampled on the edge that takes the enable
    assert property (@(posedge clk) disable iff (reset)
        (pxl_cen && chk_en) |-> ({red, green, blue} == exp_rgb))
    else begin
        err_cnt++;
        $display("FAIL %0t: rgb %h, expected %h", $time,
                 $sampled({red, green, blue}), $sampled(exp_rgb));
    end

    assert property (@(posedge clk) disable iff (reset)
        (pxl_cen && chk_en) |-> (lhbl_dly == exp_lhbl && lvbl_dly == exp_lvbl))
    else begin
        err_cnt++;
        $display("FAIL %0t: delayed blanking %b%b, expected %b%b", $time,
                 $sampled(lhbl_dly), $sampled(lvbl_dly), $sampled(exp_lhbl), $sampled(exp_lvbl));
    end

    assert property (@(posedge clk) disable iff (reset)
        (pxl_cen && chk_en && !(lhbl_dly && lvbl_dly)) |-> ({red, green, blue} == 12'h000))
    else begin
        err_cnt++;
        $display("FAIL %0t: colour %h during blanking", $time, $sampled({red, green, blue}));
    end

    // raster model, runs from reset release, looked at 1 ns after each edge
    always @(posedge clk) begin
        #1;
        if (ras_on) begin
            since_cen++;
            n_ras++;
            assert (hcnt == ref_h && vcnt == ref_v) else begin
                ras_err++;
                $display("FAIL %0t: raster %0d/%0d, expected %0d/%0d", $time,
                         hcnt, vcnt, ref_h, ref_v);
            end
            assert (lhbl == (ref_h < H_ACT) && lvbl == (ref_v < V_ACT)) else begin
                ras_err++;
                $display("FAIL %0t: lhbl/lvbl %b%b at %0d/%0d", $time, lhbl, lvbl, ref_h, ref_v);
            end
            if (pxl_cen) begin
                assert (since_cen == CEN_DIV) else begin
                    ras_err++;
                    $display("FAIL %0t: pixel enable after %0d clocks", $time, since_cen);
                end
                since_cen = 0;
                if (ref_h == H_TOT - 1) begin
                    ref_h = 0;
                    if (ref_v == V_TOT - 1) begin
                        ref_v = 0;
                        n_wrap++;    // full frame seen
                    end else begin
                        ref_v++;
                    end
                end else begin
                    ref_h++;
                end
            end else if (since_cen >= CEN_DIV) begin
                ras_err++;
                $display("pixel enable missing at %0t, %0d clocks without one", $time, since_cen);
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cyc++;
        if (cyc >= LIMIT) begin
            $display("timeout: run still going after %0d clock cycles", cyc);
            $display(">>> FAIL");
            $finish;
        end
    end

    // palette entry picked by the priority rules, black while blanking
    function automatic rgb_t expect_colour(pxl_t obj, pxl_t scr, logic [2:0] sel,
                                           logic [1:0] en, logic hb, logic vb);
        logic [PAL_AW-1:0] a;
        rgb_t              c;
        if (obj != 4'h0 && en[1]) begin
            a = {sel, 1'b0, obj};                   // sprite layer
        end else begin
            a = {sel, 1'b1, (en[0] ? scr : 4'h0)};  // tile layer
        end
        c.red   = pal[0][a];
        c.green = pal[1][a];
        c.blue  = pal[2][a];
        if (!(hb && vb)) begin
            c = '0;
        end
        return c;
    endfunction

    // 2 ns after the edge that raised pxl_cen
    task automatic wait_cen();
        @(posedge clk);
        #2;
        while (!pxl_cen) begin
            @(posedge clk);
            #2;
        end
    endtask

    // head of the queue becomes the value due on this enable's edge
    task automatic pop_expected();
        exp_t head;
        head     = exp_q.pop_front();
        exp_rgb  = head.rgb;
        exp_lhbl = head.lhbl;
        exp_lvbl = head.lvbl;
        chk_en   = 1'b1;
        n_pix++;
        if (!(head.lhbl && head.lvbl)) begin
            n_blank++;
        end
    endtask

    task automatic drive_pixel(input pxl_t obj, input pxl_t scr, input logic [2:0] sel,
                               input logic [1:0] en);
        exp_t ent;
        wait_cen();
        if (exp_q.size() == PIPE_DLY) begin   // pipe full, head is due now
            pop_expected();
        end
        obj_pxl  = obj;
        scr_pxl  = scr;
        pal_sel  = sel;
        gfx_en   = en;
        ent.rgb  = expect_colour(obj, scr, sel, en, lhbl, lvbl);
        ent.lhbl = lhbl;   // level of the position being sampled
        ent.lvbl = lvbl;
        exp_q.push_back(ent);
    endtask

    // pixels still in the pipe, one per enable
    task automatic drain_queue();
        while (exp_q.size() > 0) begin
            wait_cen();
            pop_expected();
        end
        wait_cen();
        chk_en = 1'b0;
    endtask

    task automatic check_idle();
        assert (!pxl_cen && !lhbl_dly && !lvbl_dly && {red, green, blue} == 12'h000
                && hcnt == 9'd0 && vcnt == 9'd0) else begin
            err_cnt++;
            $display("FAIL %0t: outputs not idle around reset", $time);
        end
    endtask

    task automatic load_palette();
        for (int a = 0; a < 2 ** PAL_AW; a++) begin
            for (int ch = 0; ch < 3; ch++) begin
                pal[ch][a] = chan_t'($urandom);
                prog_addr  = a[PAL_AW-1:0];
                prog_data  = pal[ch][a];
                prog_en    = 3'(1 << ch);   // red, green, blue in turn
                @(posedge clk);
                #2;
            end
        end
        prog_en = '0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-10s done, %0d errors", name, err_cnt - errs_before);
    endtask

    initial begin
        void'($urandom(5828));
        reset     = 1'b1;
        obj_pxl   = '0;
        scr_pxl   = '0;
        pal_sel   = '0;
        gfx_en    = '0;
        prog_addr = '0;
        prog_data = '0;
        prog_en   = '0;

        // reset, then idle until the first enable
        mark = err_cnt;
        repeat (4) begin
            @(posedge clk);
            #2;
            check_idle();
        end
        reset  = 1'b0;
        ras_on = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #2;
            check_idle();
        end
        report_test("reset", mark);

        load_palette();

        // tile path over every palette bank
        mark = err_cnt;
        for (int i = 0; i < FRAME_PIX / 2; i++) begin
            drive_pixel(4'h0, pxl_t'($urandom), 3'(i % 8), 2'b11);
        end
        report_test("tile", mark);

        // sprite priority and layer enables
        mark = err_cnt;
        for (int i = 0; i < FRAME_PIX / 2; i++) begin
            case (i % 4)
                0: drive_pixel(pxl_t'($urandom_range(15, 1)), pxl_t'($urandom), 3'(i / 4), 2'b11);
                1: drive_pixel(pxl_t'($urandom_range(15, 1)), pxl_t'($urandom), 3'(i / 4), 2'b01);
                2: drive_pixel(4'h0, pxl_t'($urandom_range(15, 1)), 3'(i / 4), 2'b10);
                default: drive_pixel(4'h0, pxl_t'($urandom), 3'(i / 4), 2'b00);
            endcase
        end
        report_test("sprite", mark);

        // one frame of opaque sprites, blanking must win
        mark       = err_cnt;
        blank_mark = n_blank;
        for (int i = 0; i < FRAME_PIX; i++) begin
            drive_pixel(pxl_t'($urandom_range(15, 1)), pxl_t'($urandom), 3'($urandom), 2'b11);
        end
        assert (n_blank > blank_mark) else begin
            err_cnt++;
            $display("no blanked pixel was checked during the blanking frame");
        end
        report_test("blanking", mark);

        // random layers over two frames
        mark = err_cnt;
        for (int i = 0; i < 2 * FRAME_PIX; i++) begin
            drive_pixel(pxl_t'($urandom), pxl_t'($urandom), 3'($urandom), 2'($urandom));
        end
        drain_queue();       // last pixels come out on the following enables
        report_test("random", mark);

        // raster checks ran all along
        assert (n_wrap > 0) else begin
            ras_err++;
            $display("raster never completed a frame");
        end
        $display("test %-10s done, %0d errors, %0d frames", "raster", ras_err, n_wrap);

        $display("summary: 6 tests, %0d pixels, %0d blanked, %0d raster checks, %0d errors",
                 n_pix, n_blank, n_ras, err_cnt + ras_err);
        if (err_cnt + ras_err == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== colmix.f ====
logic/colmix_pkg.sv
logic/video_if.sv
logic/video_timing.sv
logic/pal_prom.sv
logic/blank_dly.sv
logic/colmix.sv
logic/colmix_top.sv
sim/colmix_tb.sv

// ==== Bender.yml ====
package:
  name: colmix

sources:
  - files:
      - logic/colmix_pkg.sv
      - logic/video_if.sv
      - logic/video_timing.sv
      - logic/pal_prom.sv
      - logic/blank_dly.sv
      - logic/colmix.sv
      - logic/colmix_top.sv
  - target: test
    files:
      - sim/colmix_tb.sv
